/* files.f */
hdl/oflow_pkg.sv
hdl/oflow_reg_file.sv
hdl/oflow_feature_capture.sv
hdl/oflow_similarity_metric.sv
hdl/oflow_best_match.sv
hdl/oflow_tracker_top.sv
verification/oflow_tb.sv

/* hdl/oflow_best_match.sv */
// --------------------------------------------------
// Per-frame best candidate search
// First eligible candidate with the greatest score wins
// Index wraps past 2**CAND_IDX_LEN candidates
// Report comes one cycle after the last score
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module oflow_best_match #(
	parameter int SCORE_LEN = 19,
	parameter int CAND_IDX_LEN = 4
) (
	input wire logic clk,
	input wire logic reset_N,

	// Scores from the metric
	input wire logic score_valid,
	input wire logic score_last,
	input wire logic score_eligible,
	input wire logic signed [SCORE_LEN-1:0] score,

	// Match report
	output logic match_valid,
	output logic match_found,
	output logic [CAND_IDX_LEN-1:0] match_index,
	output logic signed [SCORE_LEN-1:0] match_score
);

	import oflow_pkg::*;

	match_state_e state;
	logic [CAND_IDX_LEN-1:0] idx_cnt;
	logic best_found;
	logic [CAND_IDX_LEN-1:0] best_index;
	logic signed [SCORE_LEN-1:0] best_score;

	// Current candidate view
	logic [CAND_IDX_LEN-1:0] cur_idx;
	logic prev_found;
	logic take;

	// In IDLE the old frame's state is ignored
	assign cur_idx = (state == COLLECT) ? idx_cnt : '0;
	assign prev_found = (state == COLLECT) && best_found;

	// Strictly greater, so ties stay with the earlier one
	assign take = score_eligible && (!prev_found || (score > best_score));

	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			state <= IDLE;
			idx_cnt <= '0;
			best_found <= 1'b0;
			match_valid <= 1'b0;
			match_found <= 1'b0;
			match_index <= '0;
			match_score <= '0;
		end
		else
		begin
			match_valid <= 1'b0;
			if (score_valid && score_last)
			begin
				// Close the frame, last candidate included
				match_valid <= 1'b1;
				match_found <= take || prev_found;
				match_index <= take ? cur_idx : (prev_found ? best_index : '0);
				match_score <= take ? score : (prev_found ? best_score : '0);
				state <= IDLE;
			end
			else if (score_valid)
			begin
				state <= COLLECT;
				idx_cnt <= cur_idx + CAND_IDX_LEN'(1);
				best_found <= take || prev_found;
			end
		end
	end

	// Best-so-far payload
	always_ff @(posedge clk)
	begin
		if (score_valid && take)
		begin
			best_index <= cur_idx;
			best_score <= score;
		end
	end

endmodule

`default_nettype wire

/* hdl/oflow_feature_capture.sv */
// --------------------------------------------------
// Input side of the scoring pipeline
// One candidate per cand_valid strobe, no back-pressure
// Reference box must hold still for the whole frame
// Output lags the strobe by one cycle
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module oflow_feature_capture #(
	parameter int FEAT_LEN = 8
) (
	input wire logic clk,
	input wire logic reset_N,

	// Candidate from the detector
	input wire logic cand_valid,
	input wire logic cand_last,
	input wire logic [FEAT_LEN-1:0] cand_iou,
	input wire logic [FEAT_LEN-1:0] cand_w,
	input wire logic [FEAT_LEN-1:0] cand_h,
	input wire logic [FEAT_LEN-1:0] cand_color1,
	input wire logic [FEAT_LEN-1:0] cand_color2,
	input wire logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] cand_age,

	// Reference object
	input wire logic [FEAT_LEN-1:0] ref_w,
	input wire logic [FEAT_LEN-1:0] ref_h,
	input wire logic [FEAT_LEN-1:0] ref_color1,
	input wire logic [FEAT_LEN-1:0] ref_color2,

	// Features to the metric
	output logic feat_valid,
	output logic feat_last,
	output logic [FEAT_LEN-1:0] feat_iou,
	output logic [FEAT_LEN-1:0] feat_dw,
	output logic [FEAT_LEN-1:0] feat_dh,
	output logic [FEAT_LEN-1:0] feat_dc1,
	output logic [FEAT_LEN-1:0] feat_dc2,
	output logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] feat_age
);

	// Unsigned |a - b|, never wraps
	function automatic logic [FEAT_LEN-1:0] abs_diff(
		input logic [FEAT_LEN-1:0] a,
		input logic [FEAT_LEN-1:0] b
	);
		abs_diff = (a > b) ? (a - b) : (b - a);
	endfunction

	// Flags
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			feat_valid <= 1'b0;
			feat_last <= 1'b0;
		end
		else
		begin
			feat_valid <= cand_valid;
			// Last only counts with a strobe
			feat_last <= cand_valid && cand_last;
		end
	end

	// Payload, loaded only on a strobe
	always_ff @(posedge clk)
	begin
		if (cand_valid)
		begin
			feat_iou <= cand_iou;
			feat_dw <= abs_diff(cand_w, ref_w);
			feat_dh <= abs_diff(cand_h, ref_h);
			feat_dc1 <= abs_diff(cand_color1, ref_color1);
			feat_dc2 <= abs_diff(cand_color2, ref_color2);
			feat_age <= cand_age;
		end
	end

endmodule

`default_nettype wire

/* hdl/oflow_pkg.sv */
// --------------------------------------------------
// Shared widths and encodings for the tracker slice
// APB addresses are byte addresses on a 4-byte stride
// Default widths feed the top-level parameters only
// --------------------------------------------------
`default_nettype none

package oflow_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------

	// APB address bus
	localparam int ADDR_LEN = 8;

	// History limit and candidate age
	localparam int NUM_OF_HISTORY_FRAMES_WIDTH = 3;

	// Defaults picked up by the top level
	localparam int WEIGHT_LEN_DEF = 8;
	localparam int FEAT_LEN_DEF = 8;
	localparam int CAND_IDX_LEN_DEF = 4;

	// --------------------------------------------------
	// Register map
	// --------------------------------------------------

	typedef enum logic [ADDR_LEN-1:0]
	{
		W_IOU_ADDR = 8'h00,
		W_WIDTH_ADDR = 8'h04,
		W_HEIGHT_ADDR = 8'h08,
		W_COLOR1_ADDR = 8'h0C,
		W_COLOR2_ADDR = 8'h10,
		W_HISTORY_ADDR = 8'h14,
		NUM_OF_HISTORY_FRAMES_ADDR = 8'h18
	} reg_addr_e;

	// --------------------------------------------------
	// Best-match FSM
	// --------------------------------------------------

	// IDLE means no frame open, COLLECT means at least one candidate seen
	typedef enum logic
	{
		IDLE = 1'b0,
		COLLECT = 1'b1
	} match_state_e;

endpackage

`default_nettype wire

/* hdl/oflow_reg_file.sv */
// --------------------------------------------------
// APB slave for the scoring weights and history limit
// No wait states, no PSLVERR, no protection bits
// Unmapped addresses never raise pready
// Writes keep only the low bits of pwdata
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module oflow_reg_file #(
	parameter int WEIGHT_LEN = 8
) (
	input wire logic clk,
	input wire logic reset_N,

	// APB
	input wire logic [31:0] apb_pwdata,
	input wire logic apb_pwrite,
	input wire logic apb_psel,
	input wire logic apb_penable,
	input wire logic [oflow_pkg::ADDR_LEN-1:0] apb_addr,
	output logic apb_pready,
	output logic [31:0] apb_prdata,

	// Register levels to the metric
	output logic [WEIGHT_LEN-1:0] w_iou,
	output logic [WEIGHT_LEN-1:0] w_w,
	output logic [WEIGHT_LEN-1:0] w_h,
	output logic [WEIGHT_LEN-1:0] w_color1,
	output logic [WEIGHT_LEN-1:0] w_color2,
	output logic [WEIGHT_LEN-1:0] w_dhistory,
	output logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frame
);

	import oflow_pkg::*;

	// --------------------------------------------------
	// Access decode
	// --------------------------------------------------

	logic wr_en;
	logic rd_en;
	logic addr_hit;

	// Access phase only
	assign wr_en = apb_psel && apb_penable && apb_pwrite;
	assign rd_en = apb_psel && apb_penable && !apb_pwrite;

	// One of the seven mapped addresses
	always_comb
	begin
		case (apb_addr)
			W_IOU_ADDR, W_WIDTH_ADDR, W_HEIGHT_ADDR, W_COLOR1_ADDR,
			W_COLOR2_ADDR, W_HISTORY_ADDR, NUM_OF_HISTORY_FRAMES_ADDR:
				addr_hit = 1'b1;
			default:
				addr_hit = 1'b0;
		endcase
	end

	// Ready in the same cycle, so no wait states
	assign apb_pready = (wr_en || rd_en) && addr_hit;

	// --------------------------------------------------
	// Registers
	// --------------------------------------------------

	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			w_iou <= '0;
			w_w <= '0;
			w_h <= '0;
			w_color1 <= '0;
			w_color2 <= '0;
			w_dhistory <= '0;
			num_of_history_frame <= '0;
		end
		else if (wr_en)
		begin
			// Only the addressed register moves
			case (apb_addr)
				W_IOU_ADDR: w_iou <= apb_pwdata[WEIGHT_LEN-1:0];
				W_WIDTH_ADDR: w_w <= apb_pwdata[WEIGHT_LEN-1:0];
				W_HEIGHT_ADDR: w_h <= apb_pwdata[WEIGHT_LEN-1:0];
				W_COLOR1_ADDR: w_color1 <= apb_pwdata[WEIGHT_LEN-1:0];
				W_COLOR2_ADDR: w_color2 <= apb_pwdata[WEIGHT_LEN-1:0];
				W_HISTORY_ADDR: w_dhistory <= apb_pwdata[WEIGHT_LEN-1:0];
				NUM_OF_HISTORY_FRAMES_ADDR:
					num_of_history_frame <= apb_pwdata[NUM_OF_HISTORY_FRAMES_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	// --------------------------------------------------
	// Read mux
	// --------------------------------------------------

	// Zero-extended value during a read access, 0 otherwise
	always_comb
	begin
		apb_prdata = '0;
		if (rd_en)
		begin
			case (apb_addr)
				W_IOU_ADDR: apb_prdata = 32'(w_iou);
				W_WIDTH_ADDR: apb_prdata = 32'(w_w);
				W_HEIGHT_ADDR: apb_prdata = 32'(w_h);
				W_COLOR1_ADDR: apb_prdata = 32'(w_color1);
				W_COLOR2_ADDR: apb_prdata = 32'(w_color2);
				W_HISTORY_ADDR: apb_prdata = 32'(w_dhistory);
				NUM_OF_HISTORY_FRAMES_ADDR: apb_prdata = 32'(num_of_history_frame);
				default: apb_prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/oflow_similarity_metric.sv */
// --------------------------------------------------
// Weighted similarity score, two register stages
// score = w_iou*iou - sum of the five weighted penalties
// SCORE_LEN must be WEIGHT_LEN + FEAT_LEN + 3
// Weights are sampled in stage one, limit in stage two
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module oflow_similarity_metric #(
	parameter int WEIGHT_LEN = 8,
	parameter int FEAT_LEN = 8,
	parameter int SCORE_LEN = 19
) (
	input wire logic clk,
	input wire logic reset_N,

	// Features from capture
	input wire logic feat_valid,
	input wire logic feat_last,
	input wire logic [FEAT_LEN-1:0] feat_iou,
	input wire logic [FEAT_LEN-1:0] feat_dw,
	input wire logic [FEAT_LEN-1:0] feat_dh,
	input wire logic [FEAT_LEN-1:0] feat_dc1,
	input wire logic [FEAT_LEN-1:0] feat_dc2,
	input wire logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] feat_age,

	// Register levels
	input wire logic [WEIGHT_LEN-1:0] w_iou,
	input wire logic [WEIGHT_LEN-1:0] w_w,
	input wire logic [WEIGHT_LEN-1:0] w_h,
	input wire logic [WEIGHT_LEN-1:0] w_color1,
	input wire logic [WEIGHT_LEN-1:0] w_color2,
	input wire logic [WEIGHT_LEN-1:0] w_dhistory,
	input wire logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frame,

	// Score to best match
	output logic score_valid,
	output logic score_last,
	output logic score_eligible,
	output logic signed [SCORE_LEN-1:0] score
);

	import oflow_pkg::*;

	localparam int PROD_LEN = WEIGHT_LEN + FEAT_LEN;

	// Stage one
	logic s1_valid;
	logic s1_last;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] s1_age;
	logic [PROD_LEN-1:0] p_iou, p_w, p_h, p_c1, p_c2, p_hist;

	// Penalty sum feeding stage two
	logic [SCORE_LEN-1:0] pen_sum;

	// --------------------------------------------------
	// Flags, two stages deep
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			score_valid <= 1'b0;
			score_last <= 1'b0;
		end
		else
		begin
			s1_valid <= feat_valid;
			s1_last <= feat_last;
			score_valid <= s1_valid;
			score_last <= s1_last;
		end
	end

	// --------------------------------------------------
	// Stage one, products
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		p_iou <= PROD_LEN'(w_iou) * PROD_LEN'(feat_iou);
		p_w <= PROD_LEN'(w_w) * PROD_LEN'(feat_dw);
		p_h <= PROD_LEN'(w_h) * PROD_LEN'(feat_dh);
		p_c1 <= PROD_LEN'(w_color1) * PROD_LEN'(feat_dc1);
		p_c2 <= PROD_LEN'(w_color2) * PROD_LEN'(feat_dc2);
		// Older candidates cost more
		p_hist <= PROD_LEN'(w_dhistory) * PROD_LEN'(feat_age);
		s1_age <= feat_age;
	end

	// --------------------------------------------------
	// Stage two, score and eligibility
	// --------------------------------------------------

	// Fits without overflow, since the age product is small
	assign pen_sum = SCORE_LEN'(p_w) + SCORE_LEN'(p_h) + SCORE_LEN'(p_c1)
		+ SCORE_LEN'(p_c2) + SCORE_LEN'(p_hist);

	always_ff @(posedge clk)
	begin
		score <= $signed(SCORE_LEN'(p_iou) - pen_sum);
		// Age equal to the limit still counts
		score_eligible <= (s1_age <= num_of_history_frame);
	end

endmodule

`default_nettype wire

/* hdl/oflow_tracker_top.sv */
// --------------------------------------------------
// Scoring slice of the object tracker
// cand_last to match_valid is exactly 4 cycles
// One candidate per cycle at most, no back-pressure
// Weights take effect the cycle after the APB write
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module oflow_tracker_top #(
	parameter int WEIGHT_LEN = oflow_pkg::WEIGHT_LEN_DEF,
	parameter int FEAT_LEN = oflow_pkg::FEAT_LEN_DEF,
	parameter int CAND_IDX_LEN = oflow_pkg::CAND_IDX_LEN_DEF,
	// Enough for the signed difference of the weighted terms
	localparam int SCORE_LEN = WEIGHT_LEN + FEAT_LEN + 3
) (
	input wire logic clk,
	input wire logic reset_N,

	// APB
	input wire logic [31:0] apb_pwdata,
	input wire logic apb_pwrite,
	input wire logic apb_psel,
	input wire logic apb_penable,
	input wire logic [oflow_pkg::ADDR_LEN-1:0] apb_addr,
	output logic apb_pready,
	output logic [31:0] apb_prdata,

	// Candidates
	input wire logic cand_valid,
	input wire logic cand_last,
	input wire logic [FEAT_LEN-1:0] cand_iou,
	input wire logic [FEAT_LEN-1:0] cand_w,
	input wire logic [FEAT_LEN-1:0] cand_h,
	input wire logic [FEAT_LEN-1:0] cand_color1,
	input wire logic [FEAT_LEN-1:0] cand_color2,
	input wire logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] cand_age,
	input wire logic [FEAT_LEN-1:0] ref_w,
	input wire logic [FEAT_LEN-1:0] ref_h,
	input wire logic [FEAT_LEN-1:0] ref_color1,
	input wire logic [FEAT_LEN-1:0] ref_color2,

	// Match report
	output logic match_valid,
	output logic match_found,
	output logic [CAND_IDX_LEN-1:0] match_index,
	output logic signed [SCORE_LEN-1:0] match_score
);

	import oflow_pkg::*;

	// Register levels
	logic [WEIGHT_LEN-1:0] w_iou, w_w, w_h, w_color1, w_color2, w_dhistory;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frame;

	// Capture to metric
	logic feat_valid, feat_last;
	logic [FEAT_LEN-1:0] feat_iou, feat_dw, feat_dh, feat_dc1, feat_dc2;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] feat_age;

	// Metric to best match
	logic score_valid, score_last, score_eligible;
	logic signed [SCORE_LEN-1:0] score;

	oflow_reg_file #(.WEIGHT_LEN(WEIGHT_LEN)) reg_file_i (
		.clk, .reset_N,
		.apb_pwdata, .apb_pwrite, .apb_psel, .apb_penable, .apb_addr,
		.apb_pready, .apb_prdata,
		.w_iou, .w_w, .w_h, .w_color1, .w_color2, .w_dhistory,
		.num_of_history_frame
	);

	// Stage 1 of 4
	oflow_feature_capture #(.FEAT_LEN(FEAT_LEN)) capture_i (
		.clk, .reset_N,
		.cand_valid, .cand_last, .cand_iou, .cand_w, .cand_h,
		.cand_color1, .cand_color2, .cand_age,
		.ref_w, .ref_h, .ref_color1, .ref_color2,
		.feat_valid, .feat_last, .feat_iou, .feat_dw, .feat_dh,
		.feat_dc1, .feat_dc2, .feat_age
	);

	// Stages 2 and 3
	oflow_similarity_metric #(
		.WEIGHT_LEN(WEIGHT_LEN),
		.FEAT_LEN(FEAT_LEN),
		.SCORE_LEN(SCORE_LEN)
	) metric_i (
		.clk, .reset_N,
		.feat_valid, .feat_last, .feat_iou, .feat_dw, .feat_dh,
		.feat_dc1, .feat_dc2, .feat_age,
		.w_iou, .w_w, .w_h, .w_color1, .w_color2, .w_dhistory,
		.num_of_history_frame,
		.score_valid, .score_last, .score_eligible, .score
	);

	// Stage 4, the report
	oflow_best_match #(
		.SCORE_LEN(SCORE_LEN),
		.CAND_IDX_LEN(CAND_IDX_LEN)
	) best_match_i (
		.clk, .reset_N,
		.score_valid, .score_last, .score_eligible, .score,
		.match_valid, .match_found, .match_index, .match_score
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the tracker testbench with Verilator and runs it.
# Pass or fail is decided from the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module oflow_tb -f files.f -o oflow_sim

./obj_dir/oflow_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0

/* verification/oflow_tb.sv */
// --------------------------------------------------
// Testbench for the tracker scoring slice
// Random APB and candidate traffic from a fixed seed
// Outputs are sampled on the falling clock edge
// Weights only change while the pipeline is empty
// Frames longer than 8 candidates are not sent
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module oflow_tb;

	import oflow_pkg::*;

	localparam int WEIGHT_LEN = WEIGHT_LEN_DEF;
	localparam int FEAT_LEN = FEAT_LEN_DEF;
	localparam int CAND_IDX_LEN = CAND_IDX_LEN_DEF;
	localparam int SCORE_LEN = WEIGHT_LEN + FEAT_LEN + 3;
	localparam int AGE_LEN = NUM_OF_HISTORY_FRAMES_WIDTH;

	// Wait limits in clock cycles
	localparam int APB_TIMEOUT = 16;
	localparam int MATCH_TIMEOUT = 64;

	// --------------------------------------------------
	// DUT signals
	// --------------------------------------------------
	logic clk;
	logic reset_N;
	logic [31:0] apb_pwdata;
	logic apb_pwrite;
	logic apb_psel;
	logic apb_penable;
	logic [ADDR_LEN-1:0] apb_addr;
	logic apb_pready;
	logic [31:0] apb_prdata;
	logic cand_valid;
	logic cand_last;
	logic [FEAT_LEN-1:0] cand_iou, cand_w, cand_h, cand_color1, cand_color2;
	logic [AGE_LEN-1:0] cand_age;
	logic [FEAT_LEN-1:0] ref_w, ref_h, ref_color1, ref_color2;
	logic match_valid;
	logic match_found;
	logic [CAND_IDX_LEN-1:0] match_index;
	logic signed [SCORE_LEN-1:0] match_score;

	// --------------------------------------------------
	// Model state
	// --------------------------------------------------
	int seed;
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int match_errors = 0;
	int match_checks = 0;
	string test_name = "none";

	// Shadow registers, index is address / 4
	int shadow [0:6];

	// Expected frame results, oldest first
	int exp_found_q [$];
	int exp_idx_q [$];
	int exp_score_q [$];
	// Cycle of each sampled cand_last
	int last_cyc_q [$];

	oflow_tracker_top #(
		.WEIGHT_LEN(WEIGHT_LEN),
		.FEAT_LEN(FEAT_LEN),
		.CAND_IDX_LEN(CAND_IDX_LEN)
	) dut_i (
		.clk, .reset_N,
		.apb_pwdata, .apb_pwrite, .apb_psel, .apb_penable, .apb_addr,
		.apb_pready, .apb_prdata,
		.cand_valid, .cand_last, .cand_iou, .cand_w, .cand_h,
		.cand_color1, .cand_color2, .cand_age,
		.ref_w, .ref_h, .ref_color1, .ref_color2,
		.match_valid, .match_found, .match_index, .match_score
	);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	// Uniform in 0 .. range-1
	function automatic int rnd(input int range);
		return $unsigned($random(seed)) % range;
	endfunction

	function automatic int absd(input int a, input int b);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// Weights are WEIGHT_LEN wide, the limit is AGE_LEN wide
	function automatic int field_mask(input int idx);
		return (idx == 6) ? ((1 << AGE_LEN) - 1) : ((1 << WEIGHT_LEN) - 1);
	endfunction

	function automatic logic [ADDR_LEN-1:0] reg_addr(input int idx);
		case (idx)
			0: reg_addr = W_IOU_ADDR;
			1: reg_addr = W_WIDTH_ADDR;
			2: reg_addr = W_HEIGHT_ADDR;
			3: reg_addr = W_COLOR1_ADDR;
			4: reg_addr = W_COLOR2_ADDR;
			5: reg_addr = W_HISTORY_ADDR;
			default: reg_addr = NUM_OF_HISTORY_FRAMES_ADDR;
		endcase
	endfunction

	// Word-aligned and within the seven-register map
	function automatic bit is_mapped(input logic [ADDR_LEN-1:0] a);
		return (a[1:0] == 2'b00) && (a <= 8'h18);
	endfunction

	// --------------------------------------------------
	// APB master
	// --------------------------------------------------

	// Setup, then up to max_wait access cycles; cycles is 0 without pready
	task automatic apb_xfer(input logic wr, input logic [ADDR_LEN-1:0] addr,
		input logic [31:0] wdata, input int max_wait,
		output logic [31:0] rdata, output int cycles);
		int waited;
		bit ready;
		begin
			waited = 0;
			ready = 0;
			rdata = '0;
			cycles = 0;
			@(posedge clk);
			apb_psel <= 1'b1;
			apb_penable <= 1'b0;
			apb_pwrite <= wr;
			apb_addr <= addr;
			apb_pwdata <= wdata;
			@(posedge clk);
			apb_penable <= 1'b1;
			while (!ready && waited < max_wait)
			begin
				@(negedge clk);
				waited++;
				if (apb_pready)
				begin
					ready = 1;
					rdata = apb_prdata;
					cycles = waited;
				end
				// Write commits on this edge
				@(posedge clk);
			end
			apb_psel <= 1'b0;
			apb_penable <= 1'b0;
			apb_pwrite <= 1'b0;
		end
	endtask

	task automatic write_reg(input int idx, input logic [31:0] data);
		logic [31:0] rdata;
		int cycles;
		begin
			apb_xfer(1'b1, reg_addr(idx), data, APB_TIMEOUT, rdata, cycles);
			checks++;
			if (cycles == 0)
			begin
				$display("Timeout: no pready on write to register %0d in %0d cycles",
					idx, APB_TIMEOUT);
				errors++;
			end
			else
			begin
				if (cycles != 1)
				begin
					$display("FAILED %s write_pready_cycle expected 1 actual %0d",
						test_name, cycles);
					errors++;
				end
				shadow[idx] = int'(data) & field_mask(idx);
			end
		end
	endtask

	task automatic read_check(input int idx);
		logic [31:0] rdata;
		int cycles;
		begin
			apb_xfer(1'b0, reg_addr(idx), '0, APB_TIMEOUT, rdata, cycles);
			checks++;
			if (cycles == 0)
			begin
				$display("Timeout: no pready on read of register %0d in %0d cycles",
					idx, APB_TIMEOUT);
				errors++;
			end
			else if (cycles != 1)
			begin
				$display("FAILED %s read_pready_cycle expected 1 actual %0d",
					test_name, cycles);
				errors++;
			end
			else if (rdata !== 32'(shadow[idx]))
			begin
				$display("FAILED %s readback reg %0d expected 0x%08h actual 0x%08h",
					test_name, idx, 32'(shadow[idx]), rdata);
				errors++;
			end
		end
	endtask

	task automatic read_all();
		for (int i = 0; i < 7; i++)
			read_check(i);
	endtask

	// Six weights from the random stream
	task automatic write_random_weights();
		for (int i = 0; i < 6; i++)
			write_reg(i, $random(seed));
	endtask

	// --------------------------------------------------
	// Candidate driver with the scoring model
	// --------------------------------------------------

	// Leaves cand_valid high so another frame may follow at once
	task automatic send_frame(input int n, input int age_lo, input int age_hi, input bit same);
		logic [FEAT_LEN-1:0] iou, cw, ch, c1, c2;
		logic [FEAT_LEN-1:0] rw, rh, rc1, rc2;
		logic [AGE_LEN-1:0] age;
		int sc;
		int best_sc;
		int best_idx;
		int found;
		begin
			found = 0;
			best_sc = 0;
			best_idx = 0;
			rw = FEAT_LEN'(rnd(256));
			rh = FEAT_LEN'(rnd(256));
			rc1 = FEAT_LEN'(rnd(256));
			rc2 = FEAT_LEN'(rnd(256));
			for (int i = 0; i < n; i++)
			begin
				// Identical candidates force a tie
				if (i == 0 || !same)
				begin
					iou = FEAT_LEN'(rnd(256));
					cw = FEAT_LEN'(rnd(256));
					ch = FEAT_LEN'(rnd(256));
					c1 = FEAT_LEN'(rnd(256));
					c2 = FEAT_LEN'(rnd(256));
					age = AGE_LEN'(age_lo + rnd(age_hi - age_lo + 1));
				end
				sc = shadow[0] * int'(iou)
					- (shadow[1] * absd(int'(cw), int'(rw))
					+ shadow[2] * absd(int'(ch), int'(rh))
					+ shadow[3] * absd(int'(c1), int'(rc1))
					+ shadow[4] * absd(int'(c2), int'(rc2))
					+ shadow[5] * int'(age));
				// Strictly greater keeps the earlier one on a tie
				if (int'(age) <= shadow[6] && (found == 0 || sc > best_sc))
				begin
					found = 1;
					best_sc = sc;
					best_idx = i;
				end
				@(posedge clk);
				cand_valid <= 1'b1;
				cand_last <= (i == n - 1);
				cand_iou <= iou;
				cand_w <= cw;
				cand_h <= ch;
				cand_color1 <= c1;
				cand_color2 <= c2;
				cand_age <= age;
				if (i == 0)
				begin
					ref_w <= rw;
					ref_h <= rh;
					ref_color1 <= rc1;
					ref_color2 <= rc2;
				end
			end
			exp_found_q.push_back(found);
			exp_idx_q.push_back(best_idx);
			exp_score_q.push_back(best_sc);
		end
	endtask

	task automatic stop_frames();
		@(posedge clk);
		cand_valid <= 1'b0;
		cand_last <= 1'b0;
	endtask

	// Until every sent frame has reported
	task automatic wait_for_matches();
		int waited;
		begin
			waited = 0;
			while (exp_found_q.size() != 0 && waited < MATCH_TIMEOUT)
			begin
				@(posedge clk);
				waited++;
			end
			if (exp_found_q.size() != 0)
			begin
				$display("Timeout: %0d frames got no match_valid within %0d cycles",
					exp_found_q.size(), MATCH_TIMEOUT);
				errors++;
			end
		end
	endtask

	// --------------------------------------------------
	// Match monitor
	// --------------------------------------------------
	always @(negedge clk)
	begin
		int exp_cyc;
		int e_found;
		int e_idx;
		int e_score;
		if (reset_N && cand_valid && cand_last)
			last_cyc_q.push_back(cyc);
		if (reset_N && match_valid)
		begin
			if (exp_found_q.size() == 0 || last_cyc_q.size() == 0)
			begin
				$display("Unexpected match_valid with no frame outstanding at cycle %0d", cyc);
				match_errors++;
			end
			else
			begin
				// Sampled cand_last plus 4 cycles
				exp_cyc = last_cyc_q.pop_front() + 4;
				e_found = exp_found_q.pop_front();
				e_idx = exp_idx_q.pop_front();
				e_score = exp_score_q.pop_front();
				match_checks++;
				if (cyc != exp_cyc)
				begin
					$display("FAILED %s match_cycle expected %0d actual %0d",
						test_name, exp_cyc, cyc);
					match_errors++;
				end
				if (int'(match_found) != e_found)
				begin
					$display("FAILED %s match_found expected %0d actual %0d",
						test_name, e_found, match_found);
					match_errors++;
				end
				if (int'(match_index) != e_idx)
				begin
					$display("FAILED %s match_index expected %0d actual %0d",
						test_name, e_idx, match_index);
					match_errors++;
				end
				if (int'(match_score) != e_score)
				begin
					$display("FAILED %s match_score expected %0d actual %0d",
						test_name, e_score, int'(match_score));
					match_errors++;
				end
			end
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		logic [ADDR_LEN-1:0] bad_addr;
		logic [31:0] rdata;
		int cycles;
		seed = 93328;
		for (int i = 0; i < 7; i++)
			shadow[i] = 0;
		reset_N <= 1'b0;
		apb_pwdata <= '0;
		apb_pwrite <= 1'b0;
		apb_psel <= 1'b0;
		apb_penable <= 1'b0;
		apb_addr <= '0;
		cand_valid <= 1'b0;
		cand_last <= 1'b0;
		cand_iou <= '0;
		cand_w <= '0;
		cand_h <= '0;
		cand_color1 <= '0;
		cand_color2 <= '0;
		cand_age <= '0;
		ref_w <= '0;
		ref_h <= '0;
		ref_color1 <= '0;
		ref_color2 <= '0;
		repeat (3) @(posedge clk);
		reset_N <= 1'b1;

		// All registers clear, monitor flags any stray match
		test_name = "reset_state";
		repeat (4) @(posedge clk);
		read_all();

		test_name = "register_round_trip";
		repeat (3)
		begin
			for (int i = 0; i < 7; i++)
				write_reg(i, $random(seed));
			read_all();
		end

		test_name = "unmapped_address";
		repeat (6)
		begin
			bad_addr = ADDR_LEN'(rnd(256));
			while (is_mapped(bad_addr))
				bad_addr = ADDR_LEN'(rnd(256));
			apb_xfer(rnd(2) == 1, bad_addr, $random(seed), 4, rdata, cycles);
			checks++;
			if (cycles != 0)
			begin
				$display("APB access to unmapped address 0x%02h raised pready", bad_addr);
				errors++;
			end
		end
		read_all();

		// Limit at maximum, every age eligible
		test_name = "frame_scoring";
		write_reg(6, 32'd7);
		repeat (6)
		begin
			write_random_weights();
			send_frame(1 + rnd(8), 0, 7, 1'b0);
			send_frame(1 + rnd(8), 0, 7, 1'b0);
			send_frame(2 + rnd(7), 0, 7, 1'b1);
			send_frame(1 + rnd(8), 0, 7, 1'b0);
			stop_frames();
			wait_for_matches();
		end

		test_name = "history_rejection";
		write_random_weights();
		write_reg(6, 32'd1);
		send_frame(1 + rnd(8), 0, 7, 1'b0);
		// Nothing eligible here
		send_frame(1 + rnd(8), 2, 7, 1'b0);
		send_frame(1 + rnd(8), 0, 3, 1'b0);
		stop_frames();
		wait_for_matches();
		write_reg(6, 32'd0);
		send_frame(1 + rnd(8), 0, 2, 1'b0);
		send_frame(1 + rnd(8), 1, 7, 1'b0);
		stop_frames();
		wait_for_matches();

		test_name = "weight_change";
		write_reg(6, 32'd3);
		repeat (4)
		begin
			write_random_weights();
			send_frame(1 + rnd(8), 0, 7, 1'b0);
			send_frame(1 + rnd(8), 0, 7, 1'b0);
			stop_frames();
			wait_for_matches();
		end
		read_all();

		// Quiet tail for late or extra reports
		repeat (10) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks + match_checks, errors + match_errors);
		if (errors + match_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
